// File: verilog/csr_pkg.sv
/* Shared definitions for the machine-mode CSR unit: addresses, causes, access structs
   and the masked write helper. Imported by every module of the unit. */
`default_nettype none

package csr_pkg;

    localparam logic [31:0] MISA_RESET = 32'h40000100; // RV32I, MXL = 1

    typedef enum logic [11:0] {
        MSTATUS    = 12'h300,
        MISA       = 12'h301,
        MIE        = 12'h304,
        MTVEC      = 12'h305,
        MSCRATCH   = 12'h340,
        MEPC       = 12'h341,
        MCAUSE     = 12'h342,
        MTVAL      = 12'h343,
        MIP        = 12'h344,
        MVMCTL     = 12'h7C0, // Custom protection window
        MVMDB      = 12'h7C1,
        MVMDL      = 12'h7C2,
        MVMIB      = 12'h7C3,
        MVMIL      = 12'h7C4,
        MCYCLE     = 12'hB00,
        MINSTRET   = 12'hB02,
        MCYCLEH    = 12'hB80,
        MINSTRETH  = 12'hB82,
        CYCLE      = 12'hC00, // User aliases, read only
        TIME       = 12'hC01,
        INSTRET    = 12'hC02,
        CYCLEH     = 12'hC80,
        TIMEH      = 12'hC81,
        INSTRETH   = 12'hC82,
        MVENDORID  = 12'hF11,
        MARCHID    = 12'hF12,
        MIMPID     = 12'hF13,
        MHARTID    = 12'hF14,
        MCONFIGPTR = 12'hF15
    } csr_addr_e;

    // Encodings follow funct3[1:0] of CSRRW/CSRRS/CSRRC
    typedef enum logic [1:0] {
        WRITE = 2'b01,
        SET   = 2'b10,
        CLEAR = 2'b11
    } csr_op_e;

    typedef enum logic [4:0] {
        INSTR_ADDR_MISALIGNED = 5'd0,
        INSTR_ACCESS_FAULT    = 5'd1,
        ILLEGAL_INSTRUCTION   = 5'd2,
        BREAKPOINT            = 5'd3,
        LOAD_ACCESS_FAULT     = 5'd5,
        STORE_ACCESS_FAULT    = 5'd7,
        ECALL_FROM_UMODE      = 5'd8,
        ECALL_FROM_MMODE      = 5'd11
    } exc_code_e;

    typedef enum logic [4:0] {
        M_SW_INT  = 5'd3,
        M_TIM_INT = 5'd7,
        M_EXT_INT = 5'd11
    } irq_code_e;

    typedef enum logic [1:0] {
        U = 2'b00,
        M = 2'b11
    } priv_e;

    typedef struct packed {
        logic        read;
        logic        write;
        logic        killed; // Squashed by the pipeline
        csr_op_e     op;
        logic [11:0] addr;   // Raw, may hold unsupported addresses
        logic [31:0] wdata;
    } csr_access_t;

    typedef struct packed {
        logic        raise;
        logic        mret;
        exc_code_e   exc_code;
        logic [31:0] pc;
        logic [31:0] instr;
        logic        jump;        // Interrupted instruction was a taken jump
        logic [31:0] jump_target;
    } trap_req_t;

    typedef struct packed {
        logic [18:0] rsvd_31_13;
        priv_e       mpp;
        logic [2:0]  rsvd_10_8;
        logic        mpie;
        logic [2:0]  rsvd_6_4;
        logic        mie;
        logic [2:0]  rsvd_2_0;
    } mstatus_f_t;

    // Raw view for masked writes, field view for trap handling
    typedef union packed {
        logic [31:0] raw;
        mstatus_f_t  f;
    } mstatus_u;

    typedef enum logic [2:0] {
        CNT_NONE,
        CNT_MCYCLE_LO,
        CNT_MCYCLE_HI,
        CNT_MINSTRET_LO,
        CNT_MINSTRET_HI
    } cnt_sel_e;

    typedef struct packed {
        cnt_sel_e    sel;
        logic [31:0] data;
    } cnt_wr_t;

    // Bits outside the mask keep their current value
    function automatic logic [31:0] csr_apply_op(csr_op_e op, logic [31:0] cur,
                                                 logic [31:0] data, logic [31:0] mask);
        logic [31:0] nxt;
        case (op)
            WRITE:   nxt = data;
            SET:     nxt = cur | data;
            CLEAR:   nxt = cur & ~data;
            default: nxt = cur;
        endcase
        return (cur & ~mask) | (nxt & mask);
    endfunction

endpackage

`default_nettype wire

// File: verilog/csr_bank.sv
/* Machine CSR storage with per-register write masks, the combinational read port,
   and trap entry and return. Counter writes are forwarded to the counter block. */
`default_nettype none
`timescale 1ns/1ps

module csr_bank import csr_pkg::*; #(
    parameter int unsigned HART_ID = 0
) (
    input  logic        clk,
    input  logic        reset,
    input  csr_access_t access_i,
    input  trap_req_t   trap_i,
    input  logic        irq_ack_i,
    input  irq_code_e   irq_code_i,
    input  logic [31:0] mip_i,
    input  logic [63:0] mcycle_i,
    input  logic [63:0] minstret_i,
    input  logic [63:0] mtime_i,
    output logic [31:0] mie_o,
    output logic        mstatus_mie_o,
    output cnt_wr_t     cnt_wr_o,
    output logic [31:0] rdata_o,
    output priv_e       priv_o,
    output logic [31:0] mtvec_o,
    output logic [31:0] mepc_o,
    output logic [31:0] mvmctl_o,
    output logic [31:0] mvmdb_o,
    output logic [31:0] mvmib_o,
    output logic [31:0] mvmdl_o,
    output logic [31:0] mvmil_o
);

    mstatus_u    mstatus_q;
    priv_e       priv_q;
    logic [31:0] misa_q, mie_q, mtvec_q, mscratch_q, mepc_q, mcause_q, mtval_q;
    logic [31:0] mvmctl_q, mvmdb_q, mvmib_q, mvmdl_q, mvmil_q;

    csr_addr_e   addr;
    logic [31:0] csr_val;  // Current value at addr
    logic [31:0] wmask;    // Writable bits at addr
    cnt_sel_e    cnt_sel;
    logic [31:0] wr_data;
    logic        do_write;

    assign addr = csr_addr_e'(access_i.addr);

    // Address decode shared by the read port and the write path
    always_comb begin
        csr_val = '0;
        wmask   = '0;
        cnt_sel = CNT_NONE;
        case (addr)
            MSTATUS:   begin csr_val = mstatus_q.raw; wmask = 32'h007E19AA; end
            MISA:      begin csr_val = misa_q;        wmask = 32'h3C000000; end
            MIE:       begin csr_val = mie_q;         wmask = 32'h00000888; end
            MTVEC:     begin csr_val = mtvec_q;       wmask = 32'hFFFFFFFC; end
            MSCRATCH:  begin csr_val = mscratch_q;    wmask = '1;           end
            MEPC:      begin csr_val = mepc_q;        wmask = 32'hFFFFFFFC; end
            MCAUSE:    begin csr_val = mcause_q;      wmask = '1;           end
            MTVAL:     begin csr_val = mtval_q;       wmask = '1;           end
            MIP:       csr_val = mip_i;               // Driven by the IRQ lines
            MVMCTL:    begin csr_val = mvmctl_q;      wmask = 32'h00000001; end
            MVMDB:     begin csr_val = mvmdb_q;       wmask = 32'hFFFFFFFC; end
            MVMDL:     begin csr_val = mvmdl_q;       wmask = 32'hFFFFFFFC; end
            MVMIB:     begin csr_val = mvmib_q;       wmask = 32'hFFFFFFFC; end
            MVMIL:     begin csr_val = mvmil_q;       wmask = 32'hFFFFFFFC; end
            MCYCLE:    begin csr_val = mcycle_i[31:0];    wmask = '1; cnt_sel = CNT_MCYCLE_LO; end
            MCYCLEH:   begin csr_val = mcycle_i[63:32];   wmask = '1; cnt_sel = CNT_MCYCLE_HI; end
            MINSTRET:  begin csr_val = minstret_i[31:0];  wmask = '1; cnt_sel = CNT_MINSTRET_LO; end
            MINSTRETH: begin csr_val = minstret_i[63:32]; wmask = '1; cnt_sel = CNT_MINSTRET_HI; end
            CYCLE:     csr_val = mcycle_i[31:0];
            CYCLEH:    csr_val = mcycle_i[63:32];
            INSTRET:   csr_val = minstret_i[31:0];
            INSTRETH:  csr_val = minstret_i[63:32];
            TIME:      csr_val = mtime_i[31:0];
            TIMEH:     csr_val = mtime_i[63:32];
            MHARTID:   csr_val = 32'(HART_ID);
            default:   csr_val = '0; // ID registers and unknown addresses
        endcase
    end

    assign wr_data  = csr_apply_op(access_i.op, csr_val, access_i.wdata, wmask);
    // Traps and acks take the cycle, a pending write is dropped
    assign do_write = access_i.write && !access_i.killed &&
                      !trap_i.mret && !trap_i.raise && !irq_ack_i;

    assign rdata_o = (access_i.read && !access_i.killed) ? csr_val : '0;

    assign cnt_wr_o.sel  = do_write ? cnt_sel : CNT_NONE;
    assign cnt_wr_o.data = wr_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            mstatus_q.raw <= '0;
            priv_q        <= M;
            misa_q        <= MISA_RESET;
            mie_q         <= '0;
            mtvec_q       <= '0;
            mscratch_q    <= '0;
            mepc_q        <= '0;
            mcause_q      <= '0;
            mtval_q       <= '0;
            mvmctl_q      <= '0;
            mvmdb_q       <= '0;
            mvmib_q       <= '0;
            mvmdl_q       <= '0;
            mvmil_q       <= '0;
        end else if (trap_i.mret) begin
            mstatus_q.f.mie <= mstatus_q.f.mpie;
            priv_q          <= mstatus_q.f.mpp;
        end else if (trap_i.raise || irq_ack_i) begin
            // Common trap entry bookkeeping
            mstatus_q.f.mpp  <= priv_q;
            mstatus_q.f.mpie <= mstatus_q.f.mie;
            mstatus_q.f.mie  <= 1'b0;
            priv_q           <= M;
            if (trap_i.raise) begin
                mcause_q <= {27'b0, trap_i.exc_code};
                mepc_q   <= (trap_i.exc_code == ECALL_FROM_MMODE) ? trap_i.pc
                                                                  : trap_i.pc + 32'd4;
                mtval_q  <= (trap_i.exc_code == ILLEGAL_INSTRUCTION) ? trap_i.instr
                                                                     : trap_i.pc;
            end else begin
                mcause_q <= {1'b1, 26'b0, irq_code_i};
                mepc_q   <= trap_i.jump ? trap_i.jump_target : trap_i.pc; // Resume point
            end
        end else if (do_write) begin
            case (addr)
                MSTATUS:  mstatus_q.raw <= wr_data;
                MISA:     misa_q        <= wr_data;
                MIE:      mie_q         <= wr_data;
                MTVEC:    mtvec_q       <= wr_data;
                MSCRATCH: mscratch_q    <= wr_data;
                MEPC:     mepc_q        <= wr_data;
                MCAUSE:   mcause_q      <= wr_data;
                MTVAL:    mtval_q       <= wr_data;
                MVMCTL:   mvmctl_q      <= wr_data;
                MVMDB:    mvmdb_q       <= wr_data;
                MVMDL:    mvmdl_q       <= wr_data;
                MVMIB:    mvmib_q       <= wr_data;
                MVMIL:    mvmil_q       <= wr_data;
                default:  ; // Counters go out on cnt_wr_o
            endcase
        end
    end

    assign mie_o         = mie_q;
    assign mstatus_mie_o = mstatus_q.f.mie;
    assign priv_o        = priv_q;
    assign mtvec_o       = mtvec_q;
    assign mepc_o        = mepc_q;
    assign mvmctl_o      = mvmctl_q;
    assign mvmdb_o       = mvmdb_q;
    assign mvmib_o       = mvmib_q;
    assign mvmdl_o       = mvmdl_q;
    assign mvmil_o       = mvmil_q;

    a_trap_onehot: assert property (@(posedge clk) disable iff (reset)
        !(trap_i.mret && trap_i.raise));

    a_wdata_known: assert property (@(posedge clk) disable iff (reset)
        access_i.write |-> !$isunknown(access_i.wdata));

endmodule

`default_nettype wire

// File: verilog/irq_arbiter.sv
/* Samples the interrupt lines into mip and picks the highest-priority enabled source.
   The pending flag is registered and drops the cycle after an acknowledge. */
`default_nettype none
`timescale 1ns/1ps

module irq_arbiter import csr_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] irq_i,
    input  logic [31:0] mie_i,
    input  logic        mstatus_mie_i,
    input  logic        irq_ack_i,
    output logic [31:0] mip_o,
    output irq_code_e   irq_code_o,
    output logic        irq_pending_o
);

    logic [31:0] mip_q;
    logic [31:0] enabled;
    logic        fire;

    assign enabled = mip_q & mie_i;
    assign fire    = mstatus_mie_i && (enabled != '0) && !irq_ack_i;

    always_ff @(posedge clk) begin
        if (reset) begin
            mip_q         <= '0;
            irq_pending_o <= 1'b0;
        end else begin
            mip_q         <= irq_i;
            irq_pending_o <= fire;
        end
    end

    // External over software over timer
    always_ff @(posedge clk) begin
        if (fire) begin
            if (enabled[M_EXT_INT])
                irq_code_o <= M_EXT_INT;
            else if (enabled[M_SW_INT])
                irq_code_o <= M_SW_INT;
            else
                irq_code_o <= M_TIM_INT;
        end
    end

    assign mip_o = mip_q;

    a_code_enabled: assert property (@(posedge clk) disable iff (reset)
        irq_pending_o |-> (($past(enabled) & (32'd1 << irq_code_o)) != '0));

endmodule

`default_nettype wire

// File: verilog/hpm_counters.sv
/* Free-running 64-bit mcycle and minstret counters. Either 32-bit half can be
   written through cnt_wr_i, which replaces the increment for that cycle. */
`default_nettype none
`timescale 1ns/1ps

module hpm_counters import csr_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        retire_i,
    input  cnt_wr_t     cnt_wr_i,
    output logic [63:0] mcycle_o,
    output logic [63:0] minstret_o
);

    function automatic logic [63:0] count_next(logic [63:0] cur, logic inc,
                                               logic wr_lo, logic wr_hi,
                                               logic [31:0] data);
        if (wr_lo)
            return {cur[63:32], data};
        if (wr_hi)
            return {data, cur[31:0]};
        return cur + 64'(inc);
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            mcycle_o   <= '0;
            minstret_o <= '0;
        end else begin
            mcycle_o   <= count_next(mcycle_o, 1'b1,
                                     cnt_wr_i.sel == CNT_MCYCLE_LO,
                                     cnt_wr_i.sel == CNT_MCYCLE_HI, cnt_wr_i.data);
            minstret_o <= count_next(minstret_o, retire_i,
                                     cnt_wr_i.sel == CNT_MINSTRET_LO,
                                     cnt_wr_i.sel == CNT_MINSTRET_HI, cnt_wr_i.data);
        end
    end

    a_sel_legal: assert property (@(posedge clk) disable iff (reset)
        cnt_wr_i.sel inside {CNT_NONE, CNT_MCYCLE_LO, CNT_MCYCLE_HI,
                             CNT_MINSTRET_LO, CNT_MINSTRET_HI});

endmodule

`default_nettype wire

// File: verilog/csr_unit_top.sv
/* Top level of the machine-mode CSR unit. Connects the register bank,
   the interrupt arbiter and the cycle/instret counters. */
`default_nettype none
`timescale 1ns/1ps

module csr_unit_top import csr_pkg::*; #(
    parameter int unsigned HART_ID = 0
) (
    input  logic        clk,
    input  logic        reset,
    input  csr_access_t access_i,
    input  trap_req_t   trap_i,
    input  logic [31:0] irq_i,
    input  logic        irq_ack_i,
    input  logic        retire_i,
    input  logic [63:0] mtime_i,
    output logic [31:0] rdata_o,
    output logic        irq_pending_o,
    output priv_e       priv_o,
    output logic [31:0] mtvec_o,
    output logic [31:0] mepc_o,
    output logic [31:0] mvmctl_o,
    output logic [31:0] mvmdb_o,
    output logic [31:0] mvmib_o,
    output logic [31:0] mvmdl_o,
    output logic [31:0] mvmil_o
);

    logic [31:0] mie, mip;
    logic        mstatus_mie;
    irq_code_e   irq_code;
    cnt_wr_t     cnt_wr;
    logic [63:0] mcycle, minstret;

    csr_bank #(.HART_ID(HART_ID)) csr_bank_i (
        .clk, .reset, .access_i, .trap_i, .irq_ack_i,
        .irq_code_i(irq_code), .mip_i(mip),
        .mcycle_i(mcycle), .minstret_i(minstret), .mtime_i,
        .mie_o(mie), .mstatus_mie_o(mstatus_mie), .cnt_wr_o(cnt_wr),
        .rdata_o, .priv_o, .mtvec_o, .mepc_o,
        .mvmctl_o, .mvmdb_o, .mvmib_o, .mvmdl_o, .mvmil_o
    );

    irq_arbiter irq_arbiter_i (
        .clk, .reset, .irq_i,
        .mie_i(mie), .mstatus_mie_i(mstatus_mie), .irq_ack_i,
        .mip_o(mip), .irq_code_o(irq_code), .irq_pending_o
    );

    hpm_counters hpm_counters_i (
        .clk, .reset, .retire_i,
        .cnt_wr_i(cnt_wr), .mcycle_o(mcycle), .minstret_o(minstret)
    );

endmodule

`default_nettype wire

// File: testbench/tb_clock.sv
/* Free-running clock for the testbench, PERIOD given in ns */
`default_nettype none
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD = 100
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

endmodule

`default_nettype wire

// File: testbench/csr_unit_tb.sv
/* Testbench for the CSR unit. Drives CSR accesses, traps, interrupts and counter
   activity and checks the DUT against a shadow model with assertions. */
`default_nettype none
`timescale 1ns/1ps

module csr_unit_tb import csr_pkg::*; ();

    localparam int CLK_PERIOD     = 100;
    localparam int DRIVE_DELAY    = 5;
    localparam int TIMEOUT_CYCLES = 2000; // Sequence needs roughly 300 cycles
    localparam int I_MTVEC        = 1;
    localparam int I_MIE          = 2;
    localparam int I_MSTATUS      = 3;

    logic        clk;
    logic        reset;
    csr_access_t access;
    trap_req_t   trap;
    logic [31:0] irq;
    logic        irq_ack;
    logic        retire;
    logic [63:0] mtime;
    logic [31:0] rdata, mtvec, mepc, mvmctl, mvmdb, mvmib, mvmdl, mvmil;
    logic        irq_pending;
    priv_e       priv;

    // Shadow model
    csr_addr_e   rw_addr [4];
    logic [31:0] rw_mask [4];
    logic [31:0] shadow  [4]; // mscratch, mtvec, mie, mstatus
    logic [31:0] exp_mepc, exp_mcause, exp_mtval;
    priv_e       exp_priv;
    int          errors, checks;

    tb_clock #(.PERIOD(CLK_PERIOD)) tb_clock_i (.clk_o(clk));

    csr_unit_top #(.HART_ID(0)) csr_unit_top_i (
        .clk, .reset, .access_i(access), .trap_i(trap), .irq_i(irq), .irq_ack_i(irq_ack),
        .retire_i(retire), .mtime_i(mtime), .rdata_o(rdata), .irq_pending_o(irq_pending),
        .priv_o(priv), .mtvec_o(mtvec), .mepc_o(mepc), .mvmctl_o(mvmctl), .mvmdb_o(mvmdb),
        .mvmib_o(mvmib), .mvmdl_o(mvmdl), .mvmil_o(mvmil)
    );

    task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] exp);
        errors++;
        $display("MISMATCH at %0t ns: %s = %h, expected %h", $time, name, got, exp);
    endtask

    task automatic expect_eq(string name, logic [31:0] got, logic [31:0] exp);
        checks++;
        assert (got === exp) else report_mismatch(name, got, exp);
    endtask

    // Only writable bits follow the op
    function automatic logic [31:0] predict(csr_op_e op, logic [31:0] cur,
                                            logic [31:0] data, logic [31:0] mask);
        case (op)
            WRITE:   return (cur & ~mask) | (data & mask);
            SET:     return cur | (data & mask);
            CLEAR:   return cur & ~(data & mask);
            default: return cur;
        endcase
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic check_csr(string name, logic [11:0] addr, logic [31:0] exp,
                             logic kill = 1'b0);
        access        = '0;
        access.read   = 1'b1;
        access.killed = kill;
        access.addr   = addr;
        #1; // Read port is combinational
        expect_eq(name, rdata, exp);
        access = '0;
    endtask

    task automatic read_csr(logic [11:0] addr, output logic [31:0] val);
        access      = '0;
        access.read = 1'b1;
        access.addr = addr;
        #1;
        val    = rdata;
        access = '0;
    endtask

    task automatic write_csr(logic [11:0] addr, csr_op_e op, logic [31:0] data, logic kill);
        access        = '0;
        access.write  = 1'b1;
        access.killed = kill;
        access.op     = op;
        access.addr   = addr;
        access.wdata  = data;
        next_cycle();
        access = '0;
    endtask

    task automatic write_tracked(int idx, csr_op_e op, logic [31:0] data);
        write_csr(rw_addr[idx], op, data, 1'b0);
        shadow[idx] = predict(op, shadow[idx], data, rw_mask[idx]);
    endtask

    task automatic check_tracked();
        foreach (shadow[i])
            check_csr(rw_addr[i].name(), 12'(rw_addr[i]), shadow[i]);
    endtask

    // MPP takes the old privilege, MPIE the old MIE
    task automatic enter_trap();
        logic [31:0] ms;
        ms                = shadow[I_MSTATUS];
        ms[12:11]         = exp_priv;
        ms[7]             = ms[3];
        ms[3]             = 1'b0;
        shadow[I_MSTATUS] = ms;
        exp_priv          = M;
    endtask

    task automatic return_from_trap();
        trap      = '0;
        trap.mret = 1'b1;
        next_cycle();
        trap                 = '0;
        exp_priv             = priv_e'(shadow[I_MSTATUS][12:11]);
        shadow[I_MSTATUS][3] = shadow[I_MSTATUS][7];
    endtask

    task automatic raise_exception(exc_code_e code, logic [31:0] pc, logic [31:0] instr);
        trap          = '0;
        trap.raise    = 1'b1;
        trap.exc_code = code;
        trap.pc       = pc;
        trap.instr    = instr;
        next_cycle();
        trap = '0;
        enter_trap();
        exp_mcause = {27'b0, code};
        exp_mepc   = (code == ECALL_FROM_MMODE) ? pc : pc + 32'd4;
        exp_mtval  = (code == ILLEGAL_INSTRUCTION) ? instr : pc;
        check_csr("mcause", MCAUSE, exp_mcause);
        check_csr("mepc", MEPC, exp_mepc);
        check_csr("mtval", MTVAL, exp_mtval);
        check_csr("mstatus", MSTATUS, shadow[I_MSTATUS]);
    endtask

    task automatic take_interrupt(logic [31:0] lines);
        irq_code_e   code;
        logic        jump;
        logic [31:0] pc, target;
        write_tracked(I_MSTATUS, SET, 32'h8);
        irq = lines;
        next_cycle();
        expect_eq("irq_pending_o", 32'(irq_pending), 32'd0);
        next_cycle();
        expect_eq("irq_pending_o", 32'(irq_pending), 32'd1); // Two cycles after irq_i
        code   = lines[11] ? M_EXT_INT : (lines[3] ? M_SW_INT : M_TIM_INT);
        jump   = 1'($urandom_range(1));
        pc     = $urandom & 32'hFFFF_FFFC;
        target = $urandom & 32'hFFFF_FFFC;
        irq_ack          = 1'b1;
        trap.pc          = pc;
        trap.jump        = jump;
        trap.jump_target = target;
        next_cycle();
        irq_ack = 1'b0;
        trap    = '0;
        irq     = '0;
        enter_trap();
        exp_mcause = {1'b1, 26'b0, code};
        exp_mepc   = jump ? target : pc;
        expect_eq("irq_pending_o", 32'(irq_pending), 32'd0);
        check_csr("mcause", MCAUSE, exp_mcause);
        check_csr("mepc", MEPC, exp_mepc);
        check_csr("mstatus", MSTATUS, shadow[I_MSTATUS]);
        return_from_trap();
        next_cycle();
    endtask

    a_priv: assert property (@(posedge clk) disable iff (reset) priv == exp_priv)
        else report_mismatch("priv_o", 32'($sampled(priv)), 32'($sampled(exp_priv)));
    a_mepc: assert property (@(posedge clk) disable iff (reset) mepc == exp_mepc)
        else report_mismatch("mepc_o", $sampled(mepc), $sampled(exp_mepc));
    a_mtvec: assert property (@(posedge clk) disable iff (reset) mtvec == shadow[I_MTVEC])
        else report_mismatch("mtvec_o", $sampled(mtvec), $sampled(shadow[I_MTVEC]));

    initial begin
        csr_addr_e   zero_regs [13];
        logic [31:0] data, c0, c1, retired;
        int          idx, wait_n;
        data      = $urandom(79);
        errors    = 0;
        checks    = 0;
        reset     = 1'b1;
        access    = '0;
        trap      = '0;
        irq       = '0;
        irq_ack   = 1'b0;
        retire    = 1'b0;
        mtime     = '0;
        exp_priv  = M;
        exp_mepc  = '0;
        rw_addr   = '{MSCRATCH, MTVEC, MIE, MSTATUS};
        rw_mask   = '{32'hFFFF_FFFF, 32'hFFFF_FFFC, 32'h0000_0888, 32'h007E_19AA};
        shadow    = '{32'd0, 32'd0, 32'd0, 32'd0};
        zero_regs = '{MSTATUS, MIE, MTVEC, MSCRATCH, MEPC, MCAUSE, MTVAL, MIP,
                      MVMCTL, MVMDB, MVMIB, MVMDL, MVMIL};
        repeat (10) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;

        check_csr("misa", MISA, MISA_RESET);
        foreach (zero_regs[i])
            check_csr(zero_regs[i].name(), 12'(zero_regs[i]), 32'd0);
        expect_eq("mvmctl_o", mvmctl, 32'd0);
        expect_eq("mvmdb_o", mvmdb, 32'd0);
        expect_eq("mvmib_o", mvmib, 32'd0);
        expect_eq("mvmdl_o", mvmdl, 32'd0);
        expect_eq("mvmil_o", mvmil, 32'd0);
        expect_eq("irq_pending_o", 32'(irq_pending), 32'd0);
        expect_eq("priv_o", 32'(priv), 32'(M));

        repeat (40) begin
            idx = $urandom_range(3);
            write_tracked(idx, csr_op_e'(2'($urandom_range(3, 1))), $urandom);
            check_csr(rw_addr[idx].name(), 12'(rw_addr[idx]), shadow[idx]);
        end
        write_csr(12'h7FF, WRITE, $urandom, 1'b0); // Unknown address
        check_csr("unknown csr", 12'h7FF, 32'd0);
        check_tracked();

        write_tracked(0, WRITE, $urandom | 32'h1); // Nonzero so a killed read shows
        write_csr(MSCRATCH, WRITE, ~shadow[0], 1'b1);
        check_csr("mscratch (killed read)", MSCRATCH, 32'd0, 1'b1);
        check_tracked();

        raise_exception(ECALL_FROM_MMODE, $urandom & 32'hFFFF_FFFC, $urandom);
        return_from_trap();
        write_tracked(I_MSTATUS, WRITE, 32'h0000_0088); // MPP = U, MPIE and MIE set
        return_from_trap();
        check_csr("mstatus", MSTATUS, shadow[I_MSTATUS]);
        raise_exception(ILLEGAL_INSTRUCTION, $urandom & 32'hFFFF_FFFC, $urandom);
        return_from_trap();
        check_csr("mstatus", MSTATUS, shadow[I_MSTATUS]);

        write_tracked(I_MIE, WRITE, 32'hFFFF_FFFF);
        repeat (6)
            take_interrupt($urandom | (32'h8 << (4 * $urandom_range(2))));

        read_csr(MCYCLE, c0);
        wait_n = $urandom_range(20, 5);
        repeat (wait_n) next_cycle();
        read_csr(MCYCLE, c1);
        expect_eq("mcycle delta", c1 - c0, 32'(wait_n));
        data = $urandom & 32'h0FFF_FFFF;
        write_csr(MINSTRET, WRITE, data, 1'b0);
        retired = '0;
        repeat (30) begin
            retire  = 1'($urandom_range(1));
            retired = retired + {31'b0, retire};
            next_cycle();
        end
        retire = 1'b0;
        check_csr("minstret", MINSTRET, data + retired);
        check_csr("instret", INSTRET, data + retired);
        mtime = {$urandom, $urandom};
        check_csr("time", TIME, mtime[31:0]);
        check_csr("timeh", TIMEH, mtime[63:32]);
        next_cycle();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("Timeout after %0d cycles, run did not complete, errors: %0d",
                 TIMEOUT_CYCLES, errors);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: csr_unit.f
verilog/csr_pkg.sv
verilog/csr_bank.sv
verilog/irq_arbiter.sv
verilog/hpm_counters.sv
verilog/csr_unit_top.sv
testbench/tb_clock.sv
testbench/csr_unit_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the CSR unit testbench with Verilator and runs it.
# Exits non-zero unless the testbench reports a pass.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module csr_unit_tb \
    -f csr_unit.f \
    --Mdir obj_dir -o csr_unit_sim

output=$(./obj_dir/csr_unit_sim 2>&1)
echo "$output"

if echo "$output" | grep -qxF -- '*** PASSED ***'; then
    exit 0
else
    exit 1
fi
